//--- build.f
logic/mlp_pkg.sv
logic/weight_ram.sv
logic/mlp_sequencer.sv
logic/hidden_layer.sv
logic/output_layer.sv
logic/mlp_top.sv
test/mlp_chk.sv
test/mlp_tb.sv

//--- Makefile
# Verilator build for the perceptron engine testbench

VERILATOR ?= verilator
TOP       ?= mlp_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
		echo "run result: pass"; \
	else \
		echo "run result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/mlp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mlp_tb;

    localparam int n_in    = 16;
    localparam int n_hid   = 8;
    localparam int n_out   = 4;
    localparam int acc_w   = mlp_pkg::acc_w;
    localparam int k1_end  = n_in * n_hid;
    localparam int k2_base = k1_end + n_hid;
    localparam int b2_base = k2_base + n_hid * n_out;
    localparam int n_w     = b2_base + n_out;
    localparam int addr_w  = $clog2(n_w);

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          start;
    logic [n_in-1:0]               image;
    logic                          load;
    logic [addr_w-1:0]             load_addr;
    logic [mlp_pkg::weight_w-1:0]  load_data;
    logic                          busy;
    logic                          finish;
    logic [n_out*acc_w-1:0]        scores;

    // model copy of the weight memory and the expected scores
    logic signed [mlp_pkg::weight_w-1:0] wmem [n_w];
    logic [n_out*acc_w-1:0]              exp_scores;
    logic [n_out*acc_w-1:0]              held;
    logic [31:0]                         rng = 32'd36;

    always #2 clk = ~clk;

    mlp_top #(
        .n_in  (n_in),
        .n_hid (n_hid),
        .n_out (n_out)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .image     (image),
        .load      (load),
        .load_addr (load_addr),
        .load_data (load_data),
        .busy      (busy),
        .finish    (finish),
        .scores    (scores)
    );

    bind mlp_top mlp_chk #(
        .n_in  (n_in),
        .n_hid (n_hid),
        .n_out (n_out)
    ) u_chk (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .load   (load),
        .busy   (busy),
        .finish (finish),
        .scores (scores)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // any concurrent assertion in the checker ends the run here
    always @(negedge clk) begin
        if (dut0.u_chk.failed === 1'b1)
            stop_with_error($sformatf("ERR %0t: concurrent assertion failed in mlp_chk", $time));
    end

    // ============================================================
    // reference model
    // ============================================================
    task automatic compute_expected(input logic [n_in-1:0] img);
        int     h [n_hid];
        int     s;
        longint p;
        for (int j = 0; j < n_hid; j++) begin
            h[j] = 0;
            for (int i = 0; i < n_in; i++) begin
                if (img[i])
                    h[j] += int'(wmem[i*n_hid + j]);
            end
            h[j] += int'(wmem[k1_end + j]);
            if (h[j] < 0)
                h[j] = 0;
        end
        for (int k = 0; k < n_out; k++) begin
            s = 0;
            for (int j = 0; j < n_hid; j++) begin
                p = longint'(wmem[k2_base + j*n_out + k]) * longint'(h[j]);
                s += int'(p[31:0]) >>> mlp_pkg::prod_shift;
            end
            s += int'(wmem[b2_base + k]);
            exp_scores[k*acc_w +: acc_w] = s;
        end
    endtask

    // ============================================================
    // stimulus helpers
    // ============================================================
    // relu_mode gives a small hidden kernel and strongly negative biases for half the neurons
    task automatic load_random(input bit relu_mode);
        logic [mlp_pkg::weight_w-1:0] w;
        for (int a = 0; a < n_w; a++) begin
            rng = xorshift(rng);
            w = rng[mlp_pkg::weight_w-1:0];
            if (relu_mode && a < k1_end)
                w = {{4{rng[7]}}, rng[7:0]};
            else if (relu_mode && a >= k1_end && a < k1_end + n_hid / 2)
                w = -12'sd2000;
            @(negedge clk);
            load = 1'b1;
            load_addr = addr_w'(a);
            load_data = w;
            wmem[a] = w;
        end
        @(negedge clk);
        load = 1'b0;
    endtask

    task automatic wait_finish(input int limit);
        int n;
        n = 0;
        while (finish !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > limit)
                stop_with_error($sformatf("timeout: no finish pulse within %0d cycles", limit));
        end
    endtask

    task automatic run_inference(input bit extra_start);
        @(negedge clk);
        rng = xorshift(rng);
        image = rng[n_in-1:0];
        compute_expected(image);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (extra_start) begin
            // must be ignored while busy
            repeat (n_w / 2) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        wait_finish(2 * n_w);
        assert (scores == exp_scores)
            else stop_with_error($sformatf("ERR %0t: scores 0x%h, expected 0x%h",
                                           $time, scores, exp_scores));
    endtask

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        image      = '0;
        load       = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        exp_scores = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // basic inference, then ReLU clamping
        load_random(1'b0);
        run_inference(1'b0);
        load_random(1'b1);
        run_inference(1'b0);

        // scores hold while idle
        held = scores;
        repeat (10) @(negedge clk);
        assert (scores == held)
            else stop_with_error($sformatf("ERR %0t: idle scores 0x%h changed from 0x%h",
                                           $time, scores, held));
        run_inference(1'b1);

        // reload and back-to-back runs
        load_random(1'b0);
        repeat (3) run_inference(1'b0);

        // reset late in the run, once the first output bias is in the scores
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (n_w) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        rst = 1'b0;
        assert (!busy && scores == '0)
            else stop_with_error($sformatf("ERR %0t: busy %b scores 0x%h after reset",
                                           $time, busy, scores));
        repeat (n_w + 8) begin
            @(negedge clk);
            assert (!finish)
                else stop_with_error($sformatf("ERR %0t: finish after reset", $time));
        end
        run_inference(1'b0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mlp_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mlp_chk #(
    parameter int n_in  = 784,
    parameter int n_hid = 64,
    parameter int n_out = 10
) (
    input wire logic                            clk,
    input wire logic                            rst,
    input wire logic                            start,
    input wire logic                            load,
    input wire logic                            busy,
    input wire logic                            finish,
    input wire logic [n_out*mlp_pkg::acc_w-1:0] scores
);

    localparam int n_w = n_in * n_hid + n_hid + n_hid * n_out + n_out;

    // one sticky flag per assertion, collected into failed
    logic bad_pulse  = 1'b0;
    logic bad_accept = 1'b0;
    logic bad_timing = 1'b0;
    logic bad_load   = 1'b0;
    logic bad_scores = 1'b0;
    logic bad_hold   = 1'b0;
    logic bad_reset  = 1'b0;
    logic failed;

    assign failed = bad_pulse | bad_accept | bad_timing | bad_load
                  | bad_scores | bad_hold | bad_reset;

    // ============================================================
    // pulse shape and protocol
    // ============================================================
    a_pulse: assert property (@(posedge clk) disable iff (rst)
        finish |-> !busy ##1 !finish)
        else begin
            bad_pulse = 1'b1;
            $error("finish is not a single cycle or busy is still high");
        end

    a_accept: assert property (@(posedge clk) disable iff (rst)
        start && !busy |=> busy)
        else begin
            bad_accept = 1'b1;
            $error("start in idle did not raise busy");
        end

    // weight count plus clear, pipeline and finish cycles
    a_timing: assert property (@(posedge clk) disable iff (rst)
        start && !busy |-> ##(n_w + 4) finish)
        else begin
            bad_timing = 1'b1;
            $error("finish did not arrive at the fixed latency");
        end

    a_load: assert property (@(posedge clk) disable iff (rst)
        load |-> !busy)
        else begin
            bad_load = 1'b1;
            $error("weight load while the engine is busy");
        end

    // ============================================================
    // results
    // ============================================================
    a_scores: assert property (@(posedge clk) disable iff (rst)
        finish |-> scores == mlp_tb.exp_scores)
        else begin
            bad_scores = 1'b1;
            $error("scores differ from the reference model at finish");
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        !busy && $past(!busy && !rst) |-> $stable(scores))
        else begin
            bad_hold = 1'b1;
            $error("scores changed while idle");
        end

    a_reset: assert property (@(posedge clk)
        rst |=> !busy && !finish && scores == '0)
        else begin
            bad_reset = 1'b1;
            $error("engine not idle and cleared after reset");
        end

endmodule

`default_nettype wire

//--- logic/mlp_top.sv
`timescale 1ns/1ps
`default_nettype none

module mlp_top #(
    parameter int n_in  = 784,
    parameter int n_hid = 64,
    parameter int n_out = 10
) (
    input  wire logic                               clk,
    input  wire logic                               rst,

    // inference control
    input  wire logic                               start,
    input  wire logic [n_in-1:0]                    image,

    // weight loading, idle only
    input  wire logic                               load,
    input  wire logic [addr_w-1:0]                  load_addr,
    input  wire logic [mlp_pkg::weight_w-1:0]       load_data,

    output logic                                    busy,
    output logic                                    finish,
    output logic [n_out*mlp_pkg::acc_w-1:0]         scores
);

    // kernel1, bias1, kernel2, bias2 stored back to back
    localparam int depth  = n_in * n_hid + n_hid + n_hid * n_out + n_out;
    localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int in_w   = (n_in > 1) ? $clog2(n_in) : 1;
    localparam int hid_w  = (n_hid > 1) ? $clog2(n_hid) : 1;
    localparam int out_w  = (n_out > 1) ? $clog2(n_out) : 1;

    logic [addr_w-1:0]                      rd_addr;
    logic signed [mlp_pkg::weight_w-1:0]    rd_data;
    mlp_pkg::layer_op_t                     op;
    logic [in_w-1:0]                        in_idx;
    logic [hid_w-1:0]                       hid_idx;
    logic [out_w-1:0]                       out_idx;
    logic [n_hid*mlp_pkg::acc_w-1:0]        hidden;

    // ============================================================
    // weight store and sequencer
    // ============================================================
    weight_ram #(
        .depth (depth)
    ) u_ram (
        .clk     (clk),
        .we      (load),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    mlp_sequencer #(
        .n_in  (n_in),
        .n_hid (n_hid),
        .n_out (n_out)
    ) u_seq (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .busy    (busy),
        .finish  (finish),
        .rd_addr (rd_addr),
        .op      (op),
        .in_idx  (in_idx),
        .hid_idx (hid_idx),
        .out_idx (out_idx)
    );

    // ============================================================
    // layers
    // ============================================================
    hidden_layer #(
        .n_in  (n_in),
        .n_hid (n_hid)
    ) u_hid (
        .clk     (clk),
        .rst     (rst),
        .op      (op),
        .rd_data (rd_data),
        .in_idx  (in_idx),
        .hid_idx (hid_idx),
        .image   (image),
        .hidden  (hidden)
    );

    output_layer #(
        .n_hid (n_hid),
        .n_out (n_out)
    ) u_out (
        .clk     (clk),
        .rst     (rst),
        .op      (op),
        .rd_data (rd_data),
        .hid_idx (hid_idx),
        .out_idx (out_idx),
        .hidden  (hidden),
        .scores  (scores)
    );

endmodule

`default_nettype wire

//--- logic/output_layer.sv
`timescale 1ns/1ps
`default_nettype none

module output_layer #(
    parameter int n_hid = 64,
    parameter int n_out = 10
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire mlp_pkg::layer_op_t                     op,
    input  wire logic signed [mlp_pkg::weight_w-1:0]    rd_data,
    input  wire logic [hid_w-1:0]                       hid_idx,
    input  wire logic [out_w-1:0]                       out_idx,
    input  wire logic [n_hid*mlp_pkg::acc_w-1:0]        hidden,
    output logic [n_out*mlp_pkg::acc_w-1:0]             scores
);

    localparam int hid_w = (n_hid > 1) ? $clog2(n_hid) : 1;
    localparam int out_w = (n_out > 1) ? $clog2(n_out) : 1;
    localparam int acc_w = mlp_pkg::acc_w;

    logic signed [acc_w-1:0]                    acc [n_out];
    logic signed [acc_w-1:0]                    hid_sel;
    logic signed [acc_w+mlp_pkg::weight_w-1:0]  prod;
    logic signed [acc_w-1:0]                    prod_lo;
    logic signed [acc_w-1:0]                    addend;

    // ============================================================
    // product path
    // ============================================================
    assign hid_sel = $signed(hidden[hid_idx*acc_w +: acc_w]);
    assign prod    = rd_data * hid_sel;
    // keep the low word, then drop the fraction bits
    assign prod_lo = prod[acc_w-1:0];

    always_comb begin
        if (op == mlp_pkg::op_kernel2)
            addend = prod_lo >>> mlp_pkg::prod_shift;
        else
            addend = {{(acc_w - mlp_pkg::weight_w){rd_data[mlp_pkg::weight_w-1]}}, rd_data};
    end

    // ============================================================
    // accumulators
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < n_out; k++) begin
                acc[k] <= '0;
            end
        end else begin
            case (op)
                mlp_pkg::op_clear: begin
                    for (int k = 0; k < n_out; k++) begin
                        acc[k] <= '0;
                    end
                end
                mlp_pkg::op_kernel2,
                mlp_pkg::op_bias2,
                mlp_pkg::op_last2: acc[out_idx] <= acc[out_idx] + addend;
                default: ;
            endcase
        end
    end

    for (genvar k = 0; k < n_out; k++) begin : g_flat
        assign scores[k*acc_w +: acc_w] = acc[k];
    end

endmodule

`default_nettype wire

//--- logic/hidden_layer.sv
`timescale 1ns/1ps
`default_nettype none

module hidden_layer #(
    parameter int n_in  = 784,
    parameter int n_hid = 64
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire mlp_pkg::layer_op_t                     op,
    input  wire logic signed [mlp_pkg::weight_w-1:0]    rd_data,
    input  wire logic [in_w-1:0]                        in_idx,
    input  wire logic [hid_w-1:0]                       hid_idx,
    input  wire logic [n_in-1:0]                        image,
    output logic [n_hid*mlp_pkg::acc_w-1:0]             hidden
);

    localparam int in_w  = (n_in > 1) ? $clog2(n_in) : 1;
    localparam int hid_w = (n_hid > 1) ? $clog2(n_hid) : 1;
    localparam int acc_w = mlp_pkg::acc_w;

    logic signed [acc_w-1:0] acc    [n_hid];
    logic signed [acc_w-1:0] biased [n_hid];
    logic signed [acc_w-1:0] wext;

    assign wext = {{(acc_w - mlp_pkg::weight_w){rd_data[mlp_pkg::weight_w-1]}}, rd_data};

    // selected neuron gets the weight added, all others keep their value
    always_comb begin
        for (int j = 0; j < n_hid; j++) begin
            biased[j] = acc[j] + ((j == hid_idx) ? wext : '0);
        end
    end

    // ============================================================
    // accumulator update
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < n_hid; j++) begin
                acc[j] <= '0;
            end
        end else begin
            case (op)
                mlp_pkg::op_clear: begin
                    for (int j = 0; j < n_hid; j++) begin
                        acc[j] <= '0;
                    end
                end
                mlp_pkg::op_kernel1: begin
                    // binary pixel, so the weight is either added or skipped
                    if (image[in_idx])
                        acc <= biased;
                end
                mlp_pkg::op_bias1: acc <= biased;
                mlp_pkg::op_relu1: begin
                    // last bias then clamp every negative sum
                    for (int j = 0; j < n_hid; j++) begin
                        acc[j] <= biased[j][acc_w-1] ? '0 : biased[j];
                    end
                end
                default: ;
            endcase
        end
    end

    // flatten, neuron j in slice j
    for (genvar j = 0; j < n_hid; j++) begin : g_flat
        assign hidden[j*acc_w +: acc_w] = acc[j];
    end

endmodule

`default_nettype wire

//--- logic/mlp_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mlp_sequencer #(
    parameter int n_in  = 784,
    parameter int n_hid = 64,
    parameter int n_out = 10
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,
    output logic                        busy,
    output logic                        finish,
    output logic [addr_w-1:0]           rd_addr,
    output mlp_pkg::layer_op_t          op,
    output logic [in_w-1:0]             in_idx,
    output logic [hid_w-1:0]            hid_idx,
    output logic [out_w-1:0]            out_idx
);

    // region boundaries inside the weight memory
    localparam int b1_base = n_in * n_hid;
    localparam int b2_base = b1_base + n_hid + n_hid * n_out;
    localparam int depth   = b2_base + n_out;

    localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int in_w   = (n_in > 1) ? $clog2(n_in) : 1;
    localparam int hid_w  = (n_hid > 1) ? $clog2(n_hid) : 1;
    localparam int out_w  = (n_out > 1) ? $clog2(n_out) : 1;

    mlp_pkg::mlp_state_t state;
    mlp_pkg::layer_op_t  cur_op;
    mlp_pkg::layer_op_t  op_s1;

    logic [in_w-1:0]  in_cnt;
    logic [hid_w-1:0] hid_cnt;
    logic [out_w-1:0] out_cnt;

    logic [in_w-1:0]  in_s1;
    logic [hid_w-1:0] hid_s1;
    logic [out_w-1:0] out_s1;

    assign busy = (state != mlp_pkg::st_idle);

    // ============================================================
    // opcode decode for the address being issued
    // ============================================================
    always_comb begin
        cur_op = mlp_pkg::op_none;
        case (state)
            mlp_pkg::st_clear: cur_op = mlp_pkg::op_clear;
            mlp_pkg::st_dense1: begin
                if (rd_addr < b1_base)
                    cur_op = mlp_pkg::op_kernel1;
                else if (hid_cnt == n_hid - 1)
                    cur_op = mlp_pkg::op_relu1;
                else
                    cur_op = mlp_pkg::op_bias1;
            end
            mlp_pkg::st_dense2: begin
                if (rd_addr < b2_base)
                    cur_op = mlp_pkg::op_kernel2;
                else if (out_cnt == n_out - 1)
                    cur_op = mlp_pkg::op_last2;
                else
                    cur_op = mlp_pkg::op_bias2;
            end
            default: cur_op = mlp_pkg::op_none;
        endcase
    end

    // ============================================================
    // state, address and index counters
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mlp_pkg::st_idle;
            rd_addr <= '0;
            in_cnt  <= '0;
            hid_cnt <= '0;
            out_cnt <= '0;
            op_s1   <= mlp_pkg::op_none;
            op      <= mlp_pkg::op_none;
            finish  <= 1'b0;
        end else begin
            // two-stage opcode delay matches the memory read latency
            op_s1  <= cur_op;
            op     <= op_s1;
            finish <= (op == mlp_pkg::op_last2);
            case (state)
                mlp_pkg::st_idle: begin
                    if (start) begin
                        state   <= mlp_pkg::st_clear;
                        rd_addr <= '0;
                        in_cnt  <= '0;
                        hid_cnt <= '0;
                        out_cnt <= '0;
                    end
                end
                mlp_pkg::st_clear: state <= mlp_pkg::st_dense1;
                mlp_pkg::st_dense1: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (cur_op == mlp_pkg::op_relu1) begin
                        hid_cnt <= '0;
                        state   <= mlp_pkg::st_dense2;
                    end else if (hid_cnt == n_hid - 1) begin
                        // end of one kernel row
                        hid_cnt <= '0;
                        in_cnt  <= (in_cnt == n_in - 1) ? '0 : in_cnt + 1'b1;
                    end else begin
                        hid_cnt <= hid_cnt + 1'b1;
                    end
                end
                mlp_pkg::st_dense2: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (cur_op == mlp_pkg::op_last2) begin
                        rd_addr <= '0;
                        out_cnt <= '0;
                        state   <= mlp_pkg::st_done;
                    end else if (out_cnt == n_out - 1) begin
                        out_cnt <= '0;
                        hid_cnt <= (hid_cnt == n_hid - 1) ? '0 : hid_cnt + 1'b1;
                    end else begin
                        out_cnt <= out_cnt + 1'b1;
                    end
                end
                mlp_pkg::st_done: begin
                    // drain until the last bias reaches the layers
                    if (op == mlp_pkg::op_last2)
                        state <= mlp_pkg::st_idle;
                end
                default: state <= mlp_pkg::st_idle;
            endcase
        end
    end

    // index pipeline, follows the opcode pipeline
    always_ff @(posedge clk) begin
        in_s1   <= in_cnt;
        hid_s1  <= hid_cnt;
        out_s1  <= out_cnt;
        in_idx  <= in_s1;
        hid_idx <= hid_s1;
        out_idx <= out_s1;
    end

endmodule

`default_nettype wire

//--- logic/weight_ram.sv
`timescale 1ns/1ps
`default_nettype none

module weight_ram #(
    parameter int depth = 1024
) (
    input  wire logic                                   clk,

    // host write port
    input  wire logic                                   we,
    input  wire logic [addr_w-1:0]                      wr_addr,
    input  wire logic [mlp_pkg::weight_w-1:0]           wr_data,

    // engine read port
    input  wire logic [addr_w-1:0]                      rd_addr,
    output logic signed [mlp_pkg::weight_w-1:0]         rd_data
);

    localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;

    logic [mlp_pkg::weight_w-1:0] mem [depth];

    // read address register, first stage of the read path
    logic [addr_w-1:0] addr_q;

    // ============================================================
    // write port and two-cycle read path
    // ============================================================
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        addr_q <= rd_addr;
        // output register, like the block RAM output latch
        rd_data <= $signed(mem[addr_q]);
    end

endmodule

`default_nettype wire

//--- logic/mlp_pkg.sv
`default_nettype none

package mlp_pkg;

    // ============================================================
    // datapath widths
    // ============================================================

    // stored weight, signed two's complement
    parameter int weight_w = 12;

    // accumulators, hidden values and output scores
    parameter int acc_w = 32;

    // fixed-point correction applied to each output-layer product
    parameter int prod_shift = 8;

    // ============================================================
    // sequencer states and layer opcodes
    // ============================================================

    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_dense1,
        st_dense2,
        st_done
    } mlp_state_t;

    // opcode that travels with each weight read from memory
    typedef enum logic [2:0] {
        op_none,
        op_clear,
        op_kernel1,
        op_bias1,
        op_relu1,
        op_kernel2,
        op_bias2,
        op_last2
    } layer_op_t;

endpackage

`default_nettype wire
